//--- Makefile
# Verilator build of the translator testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_translator \
		-f build.f -o tb_sim
	./obj_dir/tb_sim

clean:
	rm -rf obj_dir

//--- build.f
verilog/avalon_pkg.sv
verilog/burst_tracker.sv
verilog/master_translator.sv
verilog/bus_arbiter.sv
verilog/symbol_memory.sv
verilog/translator_top.sv
verif/translator_props.sv
verif/tb_translator.sv

//--- verif/tb_translator.sv
// Reads only words already written; in the concurrent test master a owns words 0-127, b 128-255
`timescale 1ns/1ns

module tb_translator import avalon_pkg::*; ();

   localparam int ADDR_W       = 8;
   localparam int BURST_W      = 4;
   localparam int MEM_WORDS    = 256;
   localparam int RESET_CYCLES = 10;
   localparam int ROUNDS       = 8;
   // Singles, burst with its single reads, read burst, partial, concurrent rounds
   localparam int NUM_TXN      = 4 + 16 + 1 + 2 + 4 * ROUNDS;
   localparam int TIMEOUT      = RESET_CYCLES + NUM_TXN * 200 + 100;

   logic                          clk;
   logic                          reset;
   logic                          a_write;
   logic                          a_read;
   logic [ADDR_W-1:0]             a_address;
   logic [BURST_W-1:0]            a_burstcount;
   logic [DATA_W-1:0]             a_writedata;
   logic [SYMBOLS_PER_WORD-1:0]   a_byteenable;
   logic                          a_waitrequest;
   logic [DATA_W-1:0]             a_readdata;
   logic                          a_readdatavalid;
   logic                          b_write;
   logic                          b_read;
   logic [ADDR_W-1:0]             b_address;
   logic [BURST_W-1:0]            b_burstcount;
   logic [DATA_W-1:0]             b_writedata;
   logic [SYMBOLS_PER_WORD-1:0]   b_byteenable;
   logic                          b_waitrequest;
   logic [DATA_W-1:0]             b_readdata;
   logic                          b_readdatavalid;

   logic [DATA_W-1:0]             model [MEM_WORDS];
   logic [DATA_W-1:0]             exp_a [$];
   logic [DATA_W-1:0]             exp_b [$];
   logic [31:0]                   lfsr;
   string                         test_name;
   // Master whose read command was last accepted
   master_sel_e                   read_owner;

   translator_top #(
      .ADDR_W    (ADDR_W),
      .BURST_W   (BURST_W),
      .MEM_WORDS (MEM_WORDS)
   ) DUT (.*);

   initial clk = 1'b0;
   always #5 clk = ~clk;

   // ----------------------------------------------------------------------
   // Random source and reference model
   // ----------------------------------------------------------------------
   // Taps 32, 22, 2, 1
   function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
      logic [31:0] bits;
      logic        fb;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
         state = {state[30:0], fb};
         bits  = {bits[30:0], fb};
      end
      return bits;
   endfunction

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
      input logic [DATA_W-1:0] new_word, input logic [SYMBOLS_PER_WORD-1:0] be);
      logic [DATA_W-1:0] result;
      result = old_word;
      for (int i = 0; i < SYMBOLS_PER_WORD; i++) begin
         if (be[i])
            result[8*i +: 8] = new_word[8*i +: 8];
      end
      return result;
   endfunction

   // ----------------------------------------------------------------------
   // Failure reporting and compare tasks
   // ----------------------------------------------------------------------
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_data(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
      if (actual !== expected)
         abort_run($sformatf("FAIL %s: data expected %h actual %h", name, expected, actual));
   endtask

   task automatic check_owner(input string name, input master_sel_e expected,
                              input master_sel_e actual);
      if (actual !== expected)
         abort_run($sformatf("FAIL %s: owner expected %s actual %s", name,
                             expected.name(), actual.name()));
   endtask

   task automatic take_beat(input master_sel_e sel);
      logic [DATA_W-1:0] expected;
      logic [DATA_W-1:0] actual;
      string             name;
      name   = $sformatf("%s/%s", test_name, sel.name());
      actual = (sel == SEL_A) ? a_readdata : b_readdata;
      if ((sel == SEL_A ? exp_a.size() : exp_b.size()) == 0) begin
         abort_run($sformatf("Read data arrived on %s with no read outstanding", sel.name()));
      end else begin
         if (sel == SEL_A)
            expected = exp_a.pop_front();
         else
            expected = exp_b.pop_front();
         check_owner(name, read_owner, sel);
         check_data(name, expected, actual);
      end
   endtask

   // Outputs are stable at the falling edge
   always @(negedge clk) begin
      if (!reset) begin
         if (a_readdatavalid)
            take_beat(SEL_A);
         if (b_readdatavalid)
            take_beat(SEL_B);
      end
   end

   // ----------------------------------------------------------------------
   // Master drivers
   // ----------------------------------------------------------------------
   task automatic drive_cmd(input int m, input logic wr, input logic rd, input int addr,
      input int n, input logic [DATA_W-1:0] data, input logic [SYMBOLS_PER_WORD-1:0] be);
      if (m == 0) begin
         a_write      <= wr;
         a_read       <= rd;
         a_address    <= ADDR_W'(addr);
         a_burstcount <= BURST_W'(n);
         a_writedata  <= data;
         a_byteenable <= be;
      end else begin
         b_write      <= wr;
         b_read       <= rd;
         b_address    <= ADDR_W'(addr);
         b_burstcount <= BURST_W'(n);
         b_writedata  <= data;
         b_byteenable <= be;
      end
   endtask

   // Returns on the rising edge that takes the beat
   task automatic wait_accept(input int m);
      do
         @(negedge clk);
      while (m == 0 ? a_waitrequest : b_waitrequest);
      @(posedge clk);
   endtask

   task automatic write_burst(input int m, input int addr, input int n,
                              input logic [SYMBOLS_PER_WORD-1:0] be, inout logic [31:0] st);
      logic [DATA_W-1:0] data;
      for (int i = 0; i < n; i++) begin
         data = take_bits(st, DATA_W);
         drive_cmd(m, 1'b1, 1'b0, addr, n, data, be);
         wait_accept(m);
         model[addr + i] = merge_bytes(model[addr + i], data, be);
      end
      drive_cmd(m, 1'b0, 1'b0, addr, n, '0, '0);
   endtask

   task automatic read_burst(input int m, input int addr, input int n);
      for (int i = 0; i < n; i++) begin
         if (m == 0)
            exp_a.push_back(model[addr + i]);
         else
            exp_b.push_back(model[addr + i]);
      end
      drive_cmd(m, 1'b0, 1'b1, addr, n, '0, '0);
      wait_accept(m);
      read_owner = (m == 0) ? SEL_A : SEL_B;
      drive_cmd(m, 1'b0, 1'b0, addr, n, '0, '0);
      while ((m == 0 ? exp_a.size() : exp_b.size()) != 0)
         @(posedge clk);
   endtask

   // Write then read back random bursts in this master's half of memory
   task automatic run_master(input int m, inout logic [31:0] st);
      int n;
      int addr;
      for (int r = 0; r < ROUNDS; r++) begin
         n    = 1 + int'(take_bits(st, BURST_W)) % 15;
         addr = m * (MEM_WORDS / 2) + int'(take_bits(st, ADDR_W - 1)) % (MEM_WORDS / 2 - n + 1);
         write_burst(m, addr, n, '1, st);
         read_burst(m, addr, n);
      end
   endtask

   // ----------------------------------------------------------------------
   // Test sequence and watchdog
   // ----------------------------------------------------------------------
   initial begin
      int                          addr;
      int                          n;
      logic [SYMBOLS_PER_WORD-1:0] be;
      logic [31:0]                 seed_a;
      logic [31:0]                 seed_b;
      lfsr         = 32'h3455df6d;
      test_name    = "reset";
      read_owner   = SEL_A;
      reset        = 1'b1;
      a_write      = 1'b0;
      a_read       = 1'b0;
      a_address    = '0;
      a_burstcount = '0;
      a_writedata  = '0;
      a_byteenable = '0;
      b_write      = 1'b0;
      b_read       = 1'b0;
      b_address    = '0;
      b_burstcount = '0;
      b_writedata  = '0;
      b_byteenable = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);

      test_name = "single";
      addr = int'(take_bits(lfsr, ADDR_W));
      write_burst(0, addr, 1, '1, lfsr);
      read_burst(0, addr, 1);
      addr = int'(take_bits(lfsr, ADDR_W));
      write_burst(1, addr, 1, '1, lfsr);
      read_burst(1, addr, 1);

      // Single reads walk the burst word by word
      test_name = "write burst";
      n    = 2 + int'(take_bits(lfsr, BURST_W)) % 14;
      addr = int'(take_bits(lfsr, ADDR_W)) % (MEM_WORDS - n + 1);
      write_burst(0, addr, n, '1, lfsr);
      for (int i = 0; i < n; i++)
         read_burst(1, addr + i, 1);

      test_name = "read burst";
      read_burst(0, addr, n);

      test_name = "partial write";
      be = SYMBOLS_PER_WORD'(take_bits(lfsr, SYMBOLS_PER_WORD));
      write_burst(1, addr, 1, be, lfsr);
      read_burst(0, addr, 1);

      test_name = "concurrent";
      seed_a = take_bits(lfsr, 32) | 32'd1;
      seed_b = take_bits(lfsr, 32) | 32'd1;
      fork
         run_master(0, seed_a);
         run_master(1, seed_b);
      join

      // Stray read beats would show up here
      repeat (20) @(posedge clk);
      if (exp_a.size() == 0 && exp_b.size() == 0) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         abort_run("Read data still outstanding at the end of the run");
      end
   end

   initial begin
      repeat (TIMEOUT) @(posedge clk);
      abort_run($sformatf("Watchdog timeout, transfers still pending after %0d cycles",
                          TIMEOUT));
   end

endmodule

//--- verif/translator_props.sv
// Bound into translator_top; memory state is taken from the u_memory instance
`timescale 1ns/1ns

module translator_props import avalon_pkg::*; #(
   parameter int ADDR_W  = 8,
   parameter int BURST_W = 4
) (
   input logic                          clk,
   input logic                          reset,
   input logic                          a_write,
   input logic                          a_read,
   input logic [ADDR_W-1:0]             a_address,
   input logic [BURST_W-1:0]            a_burstcount,
   input logic [DATA_W-1:0]             a_writedata,
   input logic [SYMBOLS_PER_WORD-1:0]   a_byteenable,
   input logic                          a_waitrequest,
   input logic                          a_readdatavalid,
   input logic                          b_write,
   input logic                          b_read,
   input logic [ADDR_W-1:0]             b_address,
   input logic [BURST_W-1:0]            b_burstcount,
   input logic [DATA_W-1:0]             b_writedata,
   input logic [SYMBOLS_PER_WORD-1:0]   b_byteenable,
   input logic                          b_waitrequest,
   input logic                          b_readdatavalid,
   input bus_op_e                       mem_op,
   input mem_state_e                    mem_state
);

   // Stalled commands stay put until accepted
   a_cmd_stable: assert property (@(posedge clk) disable iff (reset)
      (a_write || a_read) && a_waitrequest |=>
         $stable({a_write, a_read, a_address, a_burstcount, a_writedata, a_byteenable}))
      else $error("master a changed its command while waitrequest was high");

   b_cmd_stable: assert property (@(posedge clk) disable iff (reset)
      (b_write || b_read) && b_waitrequest |=>
         $stable({b_write, b_read, b_address, b_burstcount, b_writedata, b_byteenable}))
      else $error("master b changed its command while waitrequest was high");

   // Only the grant owner sees read data
   rdv_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(a_readdatavalid && b_readdatavalid))
      else $error("readdatavalid high on both masters");

   no_cmd_in_read: assert property (@(posedge clk) disable iff (reset)
      (mem_state == MEM_READ_BURST) |-> (mem_op == OP_NONE))
      else $error("memory received a command during a read burst");

endmodule

bind translator_top translator_props #(
   .ADDR_W  (ADDR_W),
   .BURST_W (BURST_W)
) u_props (
   .clk (clk), .reset (reset),
   .a_write (a_write), .a_read (a_read), .a_address (a_address),
   .a_burstcount (a_burstcount), .a_writedata (a_writedata),
   .a_byteenable (a_byteenable), .a_waitrequest (a_waitrequest),
   .a_readdatavalid (a_readdatavalid),
   .b_write (b_write), .b_read (b_read), .b_address (b_address),
   .b_burstcount (b_burstcount), .b_writedata (b_writedata),
   .b_byteenable (b_byteenable), .b_waitrequest (b_waitrequest),
   .b_readdatavalid (b_readdatavalid),
   .mem_op (mem_op), .mem_state (u_memory.state)
);

//--- verilog/avalon_pkg.sv
// Shared widths and encodings; word size is fixed at four 8-bit symbols
package avalon_pkg;

   // ----------------------------------------------------------------------
   // Bus geometry
   // ----------------------------------------------------------------------
   localparam int DATA_W           = 32;
   localparam int SYMBOLS_PER_WORD = 4;
   // Word quantity to byte quantity
   localparam int SYMBOL_SHIFT     = 2;

   // ----------------------------------------------------------------------
   // Encodings
   // ----------------------------------------------------------------------
   // Command on the universal bus
   typedef enum logic [1:0] {
      OP_NONE  = 2'd0,
      OP_READ  = 2'd1,
      OP_WRITE = 2'd2
   } bus_op_e;

   // Owner of the arbiter grant
   typedef enum logic {
      SEL_A = 1'b0,
      SEL_B = 1'b1
   } master_sel_e;

   // Slave memory FSM
   typedef enum logic {
      MEM_IDLE       = 1'b0,
      MEM_READ_BURST = 1'b1
   } mem_state_e;

endpackage

//--- verilog/burst_tracker.sv
// Constant-burst write sequencing only; steps by one word per accepted beat, no wrap
`timescale 1ns/1ns

module burst_tracker import avalon_pkg::*; #(
   parameter int ADDR_W  = 8,
   parameter int BURST_W = 4
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              begin_burst,
   input  logic                              beat_accepted,
   input  logic [ADDR_W+SYMBOL_SHIFT-1:0]    start_address,
   input  logic [BURST_W+SYMBOL_SHIFT-1:0]   start_count,
   output logic [ADDR_W+SYMBOL_SHIFT-1:0]    address,
   output logic [BURST_W+SYMBOL_SHIFT-1:0]   burstcount,
   output logic                              last_beat
);

   localparam int UA_W = ADDR_W + SYMBOL_SHIFT;
   localparam int UB_W = BURST_W + SYMBOL_SHIFT;

   logic [UA_W-1:0] address_reg;
   logic [UB_W-1:0] count_reg;

   // ----------------------------------------------------------------------
   // Address and remaining count registers
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         address_reg <= '0;
         count_reg   <= '0;
      end else if (begin_burst) begin
         if (beat_accepted) begin
            address_reg <= start_address + UA_W'(SYMBOLS_PER_WORD);
            count_reg   <= start_count - UB_W'(SYMBOLS_PER_WORD);
         end else begin
            // First beat stalled, keep the start values
            address_reg <= start_address;
            count_reg   <= start_count;
         end
      end else if (beat_accepted) begin
         address_reg <= address_reg + UA_W'(SYMBOLS_PER_WORD);
         count_reg   <= count_reg - UB_W'(SYMBOLS_PER_WORD);
      end
   end

   // Start values on the first beat, registers after that
   assign address    = begin_burst ? start_address : address_reg;
   assign burstcount = begin_burst ? start_count : count_reg;

   // One word left in the burst
   assign last_beat = (burstcount == UB_W'(SYMBOLS_PER_WORD));

endmodule

//--- verilog/bus_arbiter.sv
// Two masters, round robin, grant held per burst; a read holds the bus until its data returns
`timescale 1ns/1ns

module bus_arbiter import avalon_pkg::*; #(
   parameter int ADDR_W  = 8,
   parameter int BURST_W = 4
) (
   input  logic                              clk,
   input  logic                              reset,
   // Translator a
   input  bus_op_e                           a_op,
   input  logic [ADDR_W+SYMBOL_SHIFT-1:0]    a_address,
   input  logic [BURST_W+SYMBOL_SHIFT-1:0]   a_burstcount,
   input  logic [DATA_W-1:0]                 a_writedata,
   input  logic [SYMBOLS_PER_WORD-1:0]       a_byteenable,
   input  logic                              a_begin_burst,
   output logic                              a_waitrequest,
   output logic                              a_readdatavalid,
   // Translator b
   input  bus_op_e                           b_op,
   input  logic [ADDR_W+SYMBOL_SHIFT-1:0]    b_address,
   input  logic [BURST_W+SYMBOL_SHIFT-1:0]   b_burstcount,
   input  logic [DATA_W-1:0]                 b_writedata,
   input  logic [SYMBOLS_PER_WORD-1:0]       b_byteenable,
   input  logic                              b_begin_burst,
   output logic                              b_waitrequest,
   output logic                              b_readdatavalid,
   // Memory side
   output bus_op_e                           mem_op,
   output logic [ADDR_W+SYMBOL_SHIFT-1:0]    mem_address,
   output logic [BURST_W+SYMBOL_SHIFT-1:0]   mem_burstcount,
   output logic [DATA_W-1:0]                 mem_writedata,
   output logic [SYMBOLS_PER_WORD-1:0]       mem_byteenable,
   input  logic                              mem_waitrequest,
   input  logic                              mem_readdatavalid
);

   localparam int UB_W = BURST_W + SYMBOL_SHIFT;

   master_sel_e        owner;
   master_sel_e        next_owner;
   logic               busy;
   logic [BURST_W-1:0] beats_due;
   logic               req_a;
   logic               req_b;
   logic               forward;
   bus_op_e            sel_op;
   logic               write_done;
   logic               read_taken;
   logic               read_beat;

   // Only a burst start may claim the bus
   assign req_a = (a_op != OP_NONE) && a_begin_burst;
   assign req_b = (b_op != OP_NONE) && b_begin_burst;

   // Favor the master that did not own the bus last
   always_comb begin
      if (req_a && req_b)
         next_owner = (owner == SEL_A) ? SEL_B : SEL_A;
      else if (req_a)
         next_owner = SEL_A;
      else
         next_owner = SEL_B;
   end

   // ----------------------------------------------------------------------
   // Command mux toward the memory
   // ----------------------------------------------------------------------
   // Command path is closed while read data is still due
   assign forward = busy && (beats_due == '0);
   assign sel_op  = (owner == SEL_A) ? a_op : b_op;

   assign mem_op         = forward ? sel_op : OP_NONE;
   assign mem_address    = (owner == SEL_A) ? a_address : b_address;
   assign mem_burstcount = (owner == SEL_A) ? a_burstcount : b_burstcount;
   assign mem_writedata  = (owner == SEL_A) ? a_writedata : b_writedata;
   assign mem_byteenable = (owner == SEL_A) ? a_byteenable : b_byteenable;

   assign write_done = forward && (sel_op == OP_WRITE) && !mem_waitrequest &&
                       (mem_burstcount == UB_W'(SYMBOLS_PER_WORD));
   assign read_taken = forward && (sel_op == OP_READ) && !mem_waitrequest;
   assign read_beat  = busy && (beats_due != '0) && mem_readdatavalid;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         owner     <= SEL_B;
         busy      <= 1'b0;
         beats_due <= '0;
      end else if (!busy) begin
         if (req_a || req_b) begin
            owner <= next_owner;
            busy  <= 1'b1;
         end
      end else if (read_taken) begin
         beats_due <= mem_burstcount[UB_W-1:SYMBOL_SHIFT];
      end else if (read_beat) begin
         beats_due <= beats_due - 1'b1;
         if (beats_due == BURST_W'(1))
            busy <= 1'b0;
      end else if (write_done) begin
         busy <= 1'b0;
      end
   end

   // Replies reach only the owner; everyone else waits
   assign a_waitrequest   = !(forward && owner == SEL_A) || mem_waitrequest;
   assign b_waitrequest   = !(forward && owner == SEL_B) || mem_waitrequest;
   assign a_readdatavalid = busy && (owner == SEL_A) && mem_readdatavalid;
   assign b_readdatavalid = busy && (owner == SEL_B) && mem_readdatavalid;

endmodule

//--- verilog/master_translator.sv
// Word-addressed master with readdatavalid; read and write must not be asserted together
`timescale 1ns/1ns

module master_translator import avalon_pkg::*; #(
   parameter int ADDR_W  = 8,
   parameter int BURST_W = 4
) (
   input  logic                              clk,
   input  logic                              reset,
   // Master side
   input  logic                              write,
   input  logic                              read,
   input  logic [ADDR_W-1:0]                 address,
   input  logic [BURST_W-1:0]                burstcount,
   input  logic [DATA_W-1:0]                 writedata,
   input  logic [SYMBOLS_PER_WORD-1:0]       byteenable,
   output logic                              waitrequest,
   output logic [DATA_W-1:0]                 readdata,
   output logic                              readdatavalid,
   // Universal bus side
   output bus_op_e                           op,
   output logic [ADDR_W+SYMBOL_SHIFT-1:0]    bus_address,
   output logic [BURST_W+SYMBOL_SHIFT-1:0]   bus_burstcount,
   output logic [DATA_W-1:0]                 bus_writedata,
   output logic [SYMBOLS_PER_WORD-1:0]       bus_byteenable,
   output logic                              begin_burst,
   input  logic                              bus_waitrequest,
   input  logic [DATA_W-1:0]                 bus_readdata,
   input  logic                              bus_readdatavalid
);

   logic [ADDR_W+SYMBOL_SHIFT-1:0]  byte_address;
   logic [BURST_W+SYMBOL_SHIFT-1:0] byte_count;
   logic                            in_burst;
   logic                            beat_accepted;
   logic                            last_beat;

   // ----------------------------------------------------------------------
   // Word to byte scaling and command encoding
   // ----------------------------------------------------------------------
   assign byte_address = {address, SYMBOL_SHIFT'(0)};
   assign byte_count   = {burstcount, SYMBOL_SHIFT'(0)};

   always_comb begin
      if (write)
         op = OP_WRITE;
      else if (read)
         op = OP_READ;
      else
         op = OP_NONE;
   end

   // Reads always start a burst; writes only until the first beat is taken
   assign begin_burst   = read | (write & ~in_burst);
   assign beat_accepted = write & ~bus_waitrequest;

   // Set after the first accepted write beat, cleared by the last one
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         in_burst <= 1'b0;
      else if (beat_accepted)
         in_burst <= ~last_beat;
   end

   burst_tracker #(
      .ADDR_W  (ADDR_W),
      .BURST_W (BURST_W)
   ) u_tracker (
      .clk           (clk),
      .reset         (reset),
      .begin_burst   (begin_burst),
      .beat_accepted (beat_accepted),
      .start_address (byte_address),
      .start_count   (byte_count),
      .address       (bus_address),
      .burstcount    (bus_burstcount),
      .last_beat     (last_beat)
   );

   // Payload and replies pass straight through
   assign bus_writedata  = writedata;
   assign bus_byteenable = byteenable;
   assign waitrequest    = bus_waitrequest;
   assign readdata       = bus_readdata;
   assign readdatavalid  = bus_readdatavalid;

endmodule

//--- verilog/symbol_memory.sv
// MEM_WORDS must be a power of two no larger than 2**ADDR_W; burstcount must be nonzero
`timescale 1ns/1ns

module symbol_memory import avalon_pkg::*; #(
   parameter int ADDR_W    = 8,
   parameter int BURST_W   = 4,
   parameter int MEM_WORDS = 256
) (
   input  logic                              clk,
   input  logic                              reset,
   input  bus_op_e                           op,
   input  logic [ADDR_W+SYMBOL_SHIFT-1:0]    address,
   input  logic [BURST_W+SYMBOL_SHIFT-1:0]   burstcount,
   input  logic [DATA_W-1:0]                 writedata,
   input  logic [SYMBOLS_PER_WORD-1:0]       byteenable,
   output logic                              waitrequest,
   output logic [DATA_W-1:0]                 readdata,
   output logic                              readdatavalid
);

   localparam int IDX_W = $clog2(MEM_WORDS);

   logic [DATA_W-1:0]  mem [MEM_WORDS];
   mem_state_e         state;
   logic [IDX_W-1:0]   word_index;
   logic [IDX_W-1:0]   rd_index;
   logic [BURST_W-1:0] rd_left;
   logic               write_beat;
   logic               read_cmd;

   // Byte address to word index
   assign word_index = address[SYMBOL_SHIFT +: IDX_W];

   assign write_beat = (state == MEM_IDLE) && (op == OP_WRITE);
   assign read_cmd   = (state == MEM_IDLE) && (op == OP_READ);

   // ----------------------------------------------------------------------
   // Write port with byte lanes
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (write_beat) begin
         for (int i = 0; i < SYMBOLS_PER_WORD; i++) begin
            if (byteenable[i])
               mem[word_index][8*i +: 8] <= writedata[8*i +: 8];
         end
      end
   end

   // ----------------------------------------------------------------------
   // Read burst FSM
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state    <= MEM_IDLE;
         rd_index <= '0;
         rd_left  <= '0;
      end else begin
         case (state)
            MEM_IDLE: begin
               if (read_cmd) begin
                  state    <= MEM_READ_BURST;
                  rd_index <= word_index;
                  rd_left  <= burstcount[BURST_W+SYMBOL_SHIFT-1:SYMBOL_SHIFT];
               end
            end
            MEM_READ_BURST: begin
               rd_index <= rd_index + 1'b1;
               rd_left  <= rd_left - 1'b1;
               if (rd_left == BURST_W'(1))
                  state <= MEM_IDLE;
            end
            default: state <= MEM_IDLE;
         endcase
      end
   end

   // One beat per cycle while the burst runs, new commands held off
   assign readdatavalid = (state == MEM_READ_BURST);
   assign waitrequest   = (state == MEM_READ_BURST);
   assign readdata      = mem[rd_index];

endmodule

//--- verilog/translator_top.sv
// Two word-addressed masters share one byte-addressed memory; memory contents are not reset
`timescale 1ns/1ns

module translator_top import avalon_pkg::*; #(
   parameter int ADDR_W    = 8,
   parameter int BURST_W   = 4,
   parameter int MEM_WORDS = 256
) (
   input  logic                          clk,
   input  logic                          reset,
   // Master a
   input  logic                          a_write,
   input  logic                          a_read,
   input  logic [ADDR_W-1:0]             a_address,
   input  logic [BURST_W-1:0]            a_burstcount,
   input  logic [DATA_W-1:0]             a_writedata,
   input  logic [SYMBOLS_PER_WORD-1:0]   a_byteenable,
   output logic                          a_waitrequest,
   output logic [DATA_W-1:0]             a_readdata,
   output logic                          a_readdatavalid,
   // Master b
   input  logic                          b_write,
   input  logic                          b_read,
   input  logic [ADDR_W-1:0]             b_address,
   input  logic [BURST_W-1:0]            b_burstcount,
   input  logic [DATA_W-1:0]             b_writedata,
   input  logic [SYMBOLS_PER_WORD-1:0]   b_byteenable,
   output logic                          b_waitrequest,
   output logic [DATA_W-1:0]             b_readdata,
   output logic                          b_readdatavalid
);

   localparam int UA_W = ADDR_W + SYMBOL_SHIFT;
   localparam int UB_W = BURST_W + SYMBOL_SHIFT;

   // Translator a to arbiter
   bus_op_e                       a_op;
   logic [UA_W-1:0]               a_bus_address;
   logic [UB_W-1:0]               a_bus_burstcount;
   logic [DATA_W-1:0]             a_bus_writedata;
   logic [SYMBOLS_PER_WORD-1:0]   a_bus_byteenable;
   logic                          a_begin_burst;
   logic                          a_bus_waitrequest;
   logic                          a_bus_readdatavalid;
   // Translator b to arbiter
   bus_op_e                       b_op;
   logic [UA_W-1:0]               b_bus_address;
   logic [UB_W-1:0]               b_bus_burstcount;
   logic [DATA_W-1:0]             b_bus_writedata;
   logic [SYMBOLS_PER_WORD-1:0]   b_bus_byteenable;
   logic                          b_begin_burst;
   logic                          b_bus_waitrequest;
   logic                          b_bus_readdatavalid;
   // Arbiter to memory
   bus_op_e                       mem_op;
   logic [UA_W-1:0]               mem_address;
   logic [UB_W-1:0]               mem_burstcount;
   logic [DATA_W-1:0]             mem_writedata;
   logic [SYMBOLS_PER_WORD-1:0]   mem_byteenable;
   logic                          mem_waitrequest;
   logic [DATA_W-1:0]             mem_readdata;
   logic                          mem_readdatavalid;

   master_translator #(.ADDR_W(ADDR_W), .BURST_W(BURST_W)) u_xlat_a (
      .clk (clk), .reset (reset),
      .write (a_write), .read (a_read), .address (a_address),
      .burstcount (a_burstcount), .writedata (a_writedata), .byteenable (a_byteenable),
      .waitrequest (a_waitrequest), .readdata (a_readdata), .readdatavalid (a_readdatavalid),
      .op (a_op), .bus_address (a_bus_address), .bus_burstcount (a_bus_burstcount),
      .bus_writedata (a_bus_writedata), .bus_byteenable (a_bus_byteenable),
      .begin_burst (a_begin_burst), .bus_waitrequest (a_bus_waitrequest),
      .bus_readdata (mem_readdata), .bus_readdatavalid (a_bus_readdatavalid)
   );

   master_translator #(.ADDR_W(ADDR_W), .BURST_W(BURST_W)) u_xlat_b (
      .clk (clk), .reset (reset),
      .write (b_write), .read (b_read), .address (b_address),
      .burstcount (b_burstcount), .writedata (b_writedata), .byteenable (b_byteenable),
      .waitrequest (b_waitrequest), .readdata (b_readdata), .readdatavalid (b_readdatavalid),
      .op (b_op), .bus_address (b_bus_address), .bus_burstcount (b_bus_burstcount),
      .bus_writedata (b_bus_writedata), .bus_byteenable (b_bus_byteenable),
      .begin_burst (b_begin_burst), .bus_waitrequest (b_bus_waitrequest),
      .bus_readdata (mem_readdata), .bus_readdatavalid (b_bus_readdatavalid)
   );

   bus_arbiter #(.ADDR_W(ADDR_W), .BURST_W(BURST_W)) u_arbiter (
      .clk (clk), .reset (reset),
      .a_op (a_op), .a_address (a_bus_address), .a_burstcount (a_bus_burstcount),
      .a_writedata (a_bus_writedata), .a_byteenable (a_bus_byteenable),
      .a_begin_burst (a_begin_burst), .a_waitrequest (a_bus_waitrequest),
      .a_readdatavalid (a_bus_readdatavalid),
      .b_op (b_op), .b_address (b_bus_address), .b_burstcount (b_bus_burstcount),
      .b_writedata (b_bus_writedata), .b_byteenable (b_bus_byteenable),
      .b_begin_burst (b_begin_burst), .b_waitrequest (b_bus_waitrequest),
      .b_readdatavalid (b_bus_readdatavalid),
      .mem_op (mem_op), .mem_address (mem_address), .mem_burstcount (mem_burstcount),
      .mem_writedata (mem_writedata), .mem_byteenable (mem_byteenable),
      .mem_waitrequest (mem_waitrequest), .mem_readdatavalid (mem_readdatavalid)
   );

   symbol_memory #(
      .ADDR_W    (ADDR_W),
      .BURST_W   (BURST_W),
      .MEM_WORDS (MEM_WORDS)
   ) u_memory (
      .clk (clk), .reset (reset),
      .op (mem_op), .address (mem_address), .burstcount (mem_burstcount),
      .writedata (mem_writedata), .byteenable (mem_byteenable),
      .waitrequest (mem_waitrequest), .readdata (mem_readdata),
      .readdatavalid (mem_readdatavalid)
   );

endmodule
